//--- logic/slot_config.svh
`ifndef SLOT_CONFIG_SVH
`define SLOT_CONFIG_SVH

////////////////////////////////////////////////////////////
// field widths of the slot records
////////////////////////////////////////////////////////////

`define SLOT_ID_W      8                              // node / slot owner id
`define HOP_CNT_W      2                              // occupant counters, wrap mod 4
`define BUSY_W         2                              // busy code

`define FI_STATE_W     (`BUSY_W + `SLOT_ID_W + `HOP_CNT_W)  // busy, id, c2h
`define LOCAL_STATE_W  (`FI_STATE_W + `HOP_CNT_W)           // busy, id, c2h, c3h

////////////////////////////////////////////////////////////
// busy codes
////////////////////////////////////////////////////////////

`define BUSY_ONE_HOP   2'b00                          // occupied within one hop
`define BUSY_TWO_HOP   2'b01                          // occupied within two hops
`define BUSY_FREE      2'b10
`define BUSY_COLLISION 2'b11

`endif

//--- logic/slot_pkg.sv
`default_nettype none

`include "slot_config.svh"

package slot_pkg;

    ////////////////////////////////////////////////////////////
    // record fields
    ////////////////////////////////////////////////////////////

    typedef logic [`BUSY_W-1:0]    slot_busy_t;     // one of the BUSY_* codes
    typedef logic [`SLOT_ID_W-1:0] node_id_t;
    typedef logic [`HOP_CNT_W-1:0] hop_cnt_t;       // wraps modulo 4

    // fi entry from a received frame, top down: busy, id, c2h
    typedef logic [`FI_STATE_W-1:0] fi_state_t;

    // local record, top down: busy, id, c2h, c3h
    typedef logic [`LOCAL_STATE_W-1:0] local_state_t;

    ////////////////////////////////////////////////////////////
    // update sequencer
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        seq_idle,           // waiting for an enable edge
        seq_capture,        // latch fi entry and local record
        seq_decide,         // register the merged record
        seq_publish         // drive result and ready pulse
    } seq_state_t;

endpackage

`default_nettype wire

//--- logic/update_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "slot_config.svh"

module update_sequencer (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         enable,
    input  wire slot_pkg::node_id_t     fi_sender_id,
    input  wire slot_pkg::node_id_t     local_sender_id,
    input  wire slot_pkg::fi_state_t    fi_state,
    input  wire slot_pkg::local_state_t local_state,
    input  wire slot_pkg::local_state_t next_state,
    output slot_pkg::fi_state_t         fi_q,
    output slot_pkg::local_state_t      local_q,
    output slot_pkg::node_id_t          fi_sender_q,
    output slot_pkg::node_id_t          local_sender_q,
    output slot_pkg::local_state_t      update_state,
    output logic                        update_ready
);

    logic                   enable_q;       // enable one cycle back
    logic                   start;          // rising edge seen while idle
    slot_pkg::seq_state_t   state;
    slot_pkg::local_state_t result_q;       // merged record held for publish

    ////////////////////////////////////////////////////////////
    // enable edge detection
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            enable_q <= 1'b0;
        end else begin
            enable_q <= enable;
        end
    end

    // edges arriving mid-update are dropped here
    assign start = (state == slot_pkg::seq_idle) && enable && !enable_q;

    ////////////////////////////////////////////////////////////
    // state machine and outputs
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state        <= slot_pkg::seq_idle;
            update_state <= '0;
            update_ready <= 1'b0;
        end else begin
            update_ready <= 1'b0;                   // single cycle pulse
            case (state)
                slot_pkg::seq_idle: begin
                    if (start) begin
                        state <= slot_pkg::seq_capture;
                    end
                end
                slot_pkg::seq_capture: begin
                    state <= slot_pkg::seq_decide;
                end
                slot_pkg::seq_decide: begin
                    state <= slot_pkg::seq_publish;
                end
                slot_pkg::seq_publish: begin
                    update_state <= result_q;
                    update_ready <= 1'b1;
                    state        <= slot_pkg::seq_idle;
                end
            endcase
        end
    end

    // input copies and the merged result
    always_ff @(posedge clk) begin
        if (state == slot_pkg::seq_capture) begin
            fi_q           <= fi_state;
            local_q        <= local_state;
            fi_sender_q    <= fi_sender_id;
            local_sender_q <= local_sender_id;
        end
        if (state == slot_pkg::seq_decide) begin
            result_q <= next_state;                 // rules see the captured copies
        end
    end

    ////////////////////////////////////////////////////////////
    // assertions
    ////////////////////////////////////////////////////////////

    a_ready_one_cycle : assert property (@(posedge clk) disable iff (!reset)
        update_ready |=> !update_ready);

    // start sampled at E0, ready set at E0+3, first seen high at E0+4
    a_ready_after_start : assert property (@(posedge clk) disable iff (!reset)
        $rose(update_ready) |-> $past(start, 4));

endmodule

`default_nettype wire

//--- logic/slot_update_rules.sv
`timescale 1ns/10ps
`default_nettype none

`include "slot_config.svh"

module slot_update_rules (
    input  wire slot_pkg::fi_state_t    fi_q,
    input  wire slot_pkg::local_state_t local_q,
    input  wire slot_pkg::node_id_t     fi_sender_q,
    input  wire slot_pkg::node_id_t     local_sender_q,
    output slot_pkg::local_state_t      next_state
);

    ////////////////////////////////////////////////////////////
    // record fields
    ////////////////////////////////////////////////////////////

    slot_pkg::slot_busy_t f_busy;
    slot_pkg::node_id_t   f_id;
    slot_pkg::hop_cnt_t   f_c2h;

    slot_pkg::slot_busy_t l_busy;
    slot_pkg::node_id_t   l_id;
    slot_pkg::hop_cnt_t   l_c2h;
    slot_pkg::hop_cnt_t   l_c3h;

    slot_pkg::slot_busy_t n_busy;
    slot_pkg::node_id_t   n_id;
    slot_pkg::hop_cnt_t   n_c2h;
    slot_pkg::hop_cnt_t   n_c3h;

    assign {f_busy, f_id, f_c2h}        = fi_q;
    assign {l_busy, l_id, l_c2h, l_c3h} = local_q;

    ////////////////////////////////////////////////////////////
    // conditions and count arithmetic
    ////////////////////////////////////////////////////////////

    logic               id_match;       // fi and local name the same owner
    logic               self;           // fi sender claims the slot itself
    logic               own;            // local record is this node's slot
    logic               from_owner;     // fi sent by the local owner
    slot_pkg::hop_cnt_t c3h_add;
    slot_pkg::hop_cnt_t c2h_inc;
    slot_pkg::hop_cnt_t c2h_dec;
    slot_pkg::hop_cnt_t c3h_dec;

    assign id_match   = (f_id == l_id);
    assign self       = (fi_sender_q == f_id);
    assign own        = (l_id == local_sender_q);
    assign from_owner = (fi_sender_q == l_id);

    assign c3h_add = l_c3h + f_c2h;                   // all wrap mod 4
    assign c2h_inc = l_c2h + slot_pkg::hop_cnt_t'(1);
    assign c2h_dec = l_c2h - slot_pkg::hop_cnt_t'(1);
    assign c3h_dec = l_c3h - slot_pkg::hop_cnt_t'(1);

    ////////////////////////////////////////////////////////////
    // merge
    ////////////////////////////////////////////////////////////

    always_comb begin
        // unnamed fields follow the local record
        n_busy = l_busy;
        n_id   = l_id;
        n_c2h  = l_c2h;
        n_c3h  = l_c3h;

        if (id_match) begin
            if (f_busy == `BUSY_ONE_HOP && self) begin
                case (l_busy)
                    `BUSY_COLLISION,
                    `BUSY_TWO_HOP: begin                // owner confirmed one hop away
                        n_busy = `BUSY_ONE_HOP;
                        n_c3h  = c3h_add;
                    end
                    `BUSY_ONE_HOP: begin
                        if (!own) begin
                            n_c3h = c3h_add;            // neighbour still alive
                        end
                    end
                    default: begin
                    end
                endcase
            end else if (f_busy == `BUSY_ONE_HOP && l_busy == `BUSY_TWO_HOP) begin
                n_c3h = c3h_add;
            end
        end else begin
            case (f_busy)
                `BUSY_ONE_HOP: begin
                    if (self) begin
                        case (l_busy)
                            `BUSY_ONE_HOP: begin
                                if (!own) begin
                                    n_busy = `BUSY_COLLISION;   // two direct claimants
                                    n_c3h  = c3h_add;
                                end
                            end
                            `BUSY_TWO_HOP: begin
                                n_c2h = c2h_inc;
                                n_c3h = c3h_add;
                            end
                            `BUSY_FREE: begin                   // take over as one hop
                                n_busy = `BUSY_ONE_HOP;
                                n_id   = f_id;
                                n_c2h  = c2h_inc;
                                n_c3h  = c3h_add;
                            end
                            `BUSY_COLLISION: begin
                            end
                        endcase
                    end else begin
                        case (l_busy)
                            `BUSY_ONE_HOP: begin
                                if (own) begin
                                    n_busy = `BUSY_COLLISION;   // clash with our slot
                                end else begin
                                    n_c2h = c2h_inc;
                                    n_c3h = c3h_add;
                                end
                            end
                            `BUSY_TWO_HOP: begin
                                n_c2h = c2h_inc;
                                n_c3h = c3h_add;
                            end
                            `BUSY_FREE: begin                   // take over as two hop
                                n_busy = `BUSY_TWO_HOP;
                                n_id   = f_id;
                                n_c2h  = c2h_inc;
                                n_c3h  = c3h_add;
                            end
                            `BUSY_COLLISION: begin
                            end
                        endcase
                    end
                end

                `BUSY_TWO_HOP: begin
                    if (l_busy == `BUSY_ONE_HOP || l_busy == `BUSY_FREE) begin
                        n_c3h = c3h_add;
                    end
                end

                `BUSY_FREE: begin
                    // owner reports the slot released
                    if (from_owner && (l_busy == `BUSY_TWO_HOP ||
                                       (l_busy == `BUSY_ONE_HOP && !own))) begin
                        n_busy = `BUSY_FREE;
                        n_id   = '0;
                        n_c2h  = c2h_dec;
                        n_c3h  = c3h_dec;
                    end
                end

                `BUSY_COLLISION: begin
                    if (l_busy != `BUSY_COLLISION) begin
                        n_busy = `BUSY_TWO_HOP;             // fi winner holds the slot
                        n_id   = f_id;
                    end
                end
            endcase
        end
    end

    assign next_state = {n_busy, n_id, n_c2h, n_c3h};

endmodule

`default_nettype wire

//--- logic/slot_update_top.sv
`timescale 1ns/10ps
`default_nettype none

module slot_update_top (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    enable,
    input  wire slot_pkg::node_id_t     fi_sender_id,
    input  wire slot_pkg::node_id_t     local_sender_id,
    input  wire slot_pkg::fi_state_t    fi_state,
    input  wire slot_pkg::local_state_t local_state,
    output slot_pkg::local_state_t      update_state,
    output logic                        update_ready
);

    slot_pkg::fi_state_t    fi_q;           // captured fi entry
    slot_pkg::local_state_t local_q;        // captured local record
    slot_pkg::node_id_t     fi_sender_q;
    slot_pkg::node_id_t     local_sender_q;
    slot_pkg::local_state_t next_state;     // merged record, combinational

    update_sequencer i_sequencer (
        .clk             (clk),
        .reset           (reset),
        .enable          (enable),
        .fi_sender_id    (fi_sender_id),
        .local_sender_id (local_sender_id),
        .fi_state        (fi_state),
        .local_state     (local_state),
        .next_state      (next_state),
        .fi_q            (fi_q),
        .local_q         (local_q),
        .fi_sender_q     (fi_sender_q),
        .local_sender_q  (local_sender_q),
        .update_state    (update_state),
        .update_ready    (update_ready)
    );

    slot_update_rules i_rules (
        .fi_q           (fi_q),
        .local_q        (local_q),
        .fi_sender_q    (fi_sender_q),
        .local_sender_q (local_sender_q),
        .next_state     (next_state)
    );

endmodule

`default_nettype wire

//--- test/slot_update_cases.svh
`ifndef SLOT_UPDATE_CASES_SVH
`define SLOT_UPDATE_CASES_SVH

////////////////////////////////////////////////////////////
// one case per line: fi sender, local sender, fi entry (busy, id, c2h),
// local record and expected record (busy, id, c2h, c3h)
////////////////////////////////////////////////////////////

localparam int num_cases = 29;

task automatic load_cases();
    // same owner in fi entry and local record
    add_case(id_a, my_id, fie(hop1, id_a, 1), loc(hop2, id_a, 2, 1), loc(hop1, id_a, 2, 2));
    add_case(id_a, my_id, fie(hop1, id_a, 2), loc(coll, id_a, 1, 3), loc(hop1, id_a, 1, 1));
    add_case(id_a, my_id, fie(hop1, id_a, 1), loc(hop1, id_a, 0, 1), loc(hop1, id_a, 0, 2));
    add_case(my_id, my_id, fie(hop1, my_id, 1), loc(hop1, my_id, 1, 1), loc(hop1, my_id, 1, 1));
    add_case(id_b, my_id, fie(hop1, id_a, 3), loc(hop2, id_a, 1, 0), loc(hop2, id_a, 1, 3));
    add_case(id_b, my_id, fie(hop1, id_a, 1), loc(hop1, id_a, 2, 2), loc(hop1, id_a, 2, 2));
    add_case(id_a, my_id, fie(hop2, id_a, 1), loc(hop2, id_a, 1, 1), loc(hop2, id_a, 1, 1));
    add_case(id_a, my_id, fie(free, id_a, 0), loc(hop1, id_a, 1, 2), loc(hop1, id_a, 1, 2));
    // one hop fi entry claimed by its sender
    add_case(id_b, my_id, fie(hop1, id_b, 1), loc(hop1, id_a, 1, 1), loc(coll, id_a, 1, 2));
    add_case(id_b, my_id, fie(hop1, id_b, 2), loc(hop2, id_a, 1, 0), loc(hop2, id_a, 2, 2));
    add_case(id_b, my_id, fie(hop1, id_b, 1), loc(free, no_id, 0, 0), loc(hop1, id_b, 1, 1));
    add_case(id_b, my_id, fie(hop1, id_b, 1), loc(hop1, my_id, 2, 1), loc(hop1, my_id, 2, 1));
    add_case(id_b, my_id, fie(hop1, id_b, 1), loc(coll, id_a, 1, 1), loc(coll, id_a, 1, 1));
    // one hop fi entry relayed for another node
    add_case(id_c, my_id, fie(hop1, id_b, 1), loc(hop1, my_id, 1, 2), loc(coll, my_id, 1, 2));
    add_case(id_c, my_id, fie(hop1, id_b, 2), loc(hop1, id_a, 3, 3), loc(hop1, id_a, 0, 1));
    add_case(id_c, my_id, fie(hop1, id_b, 1), loc(hop2, id_a, 0, 1), loc(hop2, id_a, 1, 2));
    add_case(id_c, my_id, fie(hop1, id_b, 3), loc(free, no_id, 0, 0), loc(hop2, id_b, 1, 3));
    add_case(id_c, my_id, fie(hop1, id_b, 1), loc(coll, id_a, 2, 2), loc(coll, id_a, 2, 2));
    // two hop and free fi entries
    add_case(id_c, my_id, fie(hop2, id_b, 2), loc(hop1, id_a, 1, 1), loc(hop1, id_a, 1, 3));
    add_case(id_b, my_id, fie(hop2, id_b, 1), loc(free, no_id, 0, 2), loc(free, no_id, 0, 3));
    add_case(id_c, my_id, fie(hop2, id_b, 1), loc(hop2, id_a, 1, 1), loc(hop2, id_a, 1, 1));
    add_case(id_c, my_id, fie(hop2, id_b, 1), loc(coll, id_a, 1, 1), loc(coll, id_a, 1, 1));
    add_case(id_a, my_id, fie(free, id_b, 0), loc(hop2, id_a, 2, 3), loc(free, no_id, 1, 2));
    add_case(id_a, my_id, fie(free, id_b, 0), loc(hop1, id_a, 0, 0), loc(free, no_id, 3, 3));
    add_case(id_c, my_id, fie(free, id_b, 0), loc(hop2, id_a, 2, 3), loc(hop2, id_a, 2, 3));
    add_case(my_id, my_id, fie(free, id_b, 0), loc(hop1, my_id, 1, 1), loc(hop1, my_id, 1, 1));
    // fi entry in collision
    add_case(id_c, my_id, fie(coll, id_b, 1), loc(hop1, id_a, 2, 3), loc(hop2, id_b, 2, 3));
    add_case(id_c, my_id, fie(coll, id_b, 1), loc(free, no_id, 0, 1), loc(hop2, id_b, 0, 1));
    add_case(id_c, my_id, fie(coll, id_b, 1), loc(coll, id_a, 1, 1), loc(coll, id_a, 1, 1));
endtask

`endif

//--- test/tb_slot_update.sv
`timescale 1ns/10ps
`default_nettype none

`include "slot_config.svh"

module tb_slot_update;

    localparam slot_pkg::slot_busy_t hop1 = `BUSY_ONE_HOP;
    localparam slot_pkg::slot_busy_t hop2 = `BUSY_TWO_HOP;
    localparam slot_pkg::slot_busy_t free = `BUSY_FREE;
    localparam slot_pkg::slot_busy_t coll = `BUSY_COLLISION;

    localparam slot_pkg::node_id_t my_id = 8'h01;   // this node
    localparam slot_pkg::node_id_t id_a  = 8'h0a;
    localparam slot_pkg::node_id_t id_b  = 8'h0b;
    localparam slot_pkg::node_id_t id_c  = 8'h0c;
    localparam slot_pkg::node_id_t no_id = 8'h00;

    `include "slot_update_cases.svh"

    logic                   clk;
    logic                   reset;
    logic                   enable;
    slot_pkg::node_id_t     fi_sender_id;
    slot_pkg::node_id_t     local_sender_id;
    slot_pkg::fi_state_t    fi_state;
    slot_pkg::local_state_t local_state;
    slot_pkg::local_state_t update_state;
    logic                   update_ready;

    slot_pkg::node_id_t     case_fi_sender[num_cases];
    slot_pkg::node_id_t     case_local_sender[num_cases];
    slot_pkg::fi_state_t    case_fi[num_cases];
    slot_pkg::local_state_t case_local[num_cases];
    slot_pkg::local_state_t case_expected[num_cases];

    int                     loaded = 0;
    int                     cycle_count = 0;
    int                     check_count = 0;
    int                     error_count = 0;
    slot_pkg::local_state_t last_result;    // record the DUT should still hold
    slot_pkg::seq_state_t   seq_seen;

    slot_update_top i_dut (
        .clk             (clk),
        .reset           (reset),
        .enable          (enable),
        .fi_sender_id    (fi_sender_id),
        .local_sender_id (local_sender_id),
        .fi_state        (fi_state),
        .local_state     (local_state),
        .update_state    (update_state),
        .update_ready    (update_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // about 8 cycles per case, the rest is margin
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= 10 * num_cases + 50) begin
            seq_seen = i_dut.i_sequencer.state;
            $display("timeout expired after %0d cycles, sequencer in %s",
                     cycle_count, seq_seen.name());
            $display("Errors found");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // table helpers and checks
    ////////////////////////////////////////////////////////////

    function automatic slot_pkg::fi_state_t fie(input slot_pkg::slot_busy_t busy,
                                                input slot_pkg::node_id_t id,
                                                input slot_pkg::hop_cnt_t c2h);
        return {busy, id, c2h};
    endfunction

    function automatic slot_pkg::local_state_t loc(input slot_pkg::slot_busy_t busy,
                                                   input slot_pkg::node_id_t id,
                                                   input slot_pkg::hop_cnt_t c2h,
                                                   input slot_pkg::hop_cnt_t c3h);
        return {busy, id, c2h, c3h};
    endfunction

    task automatic add_case(input slot_pkg::node_id_t fi_sender,
                            input slot_pkg::node_id_t local_sender,
                            input slot_pkg::fi_state_t fi,
                            input slot_pkg::local_state_t local_rec,
                            input slot_pkg::local_state_t expected);
        case_fi_sender[loaded]    = fi_sender;
        case_local_sender[loaded] = local_sender;
        case_fi[loaded]           = fi;
        case_local[loaded]        = local_rec;
        case_expected[loaded]     = expected;
        loaded++;
    endtask

    task automatic check_state(input int idx, input string what,
                               input slot_pkg::local_state_t got,
                               input slot_pkg::local_state_t expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("error at %0t ns: case %0d %s is %h, expected %h",
                     $time, idx, what, got, expected);
        end
    endtask

    task automatic check_ready(input int idx, input int got_cycle, input int expected_cycle);
        check_count++;
        if (got_cycle != expected_cycle) begin
            error_count++;
            $display("error at %0t ns: case %0d ready pulse %0d cycles after enable, expected %0d",
                     $time, idx, got_cycle, expected_cycle);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // one update per table entry
    ////////////////////////////////////////////////////////////

    task automatic run_case(input int idx);
        int                     waited;
        int                     pulses;
        int                     ready_at;
        int                     errors_before;
        slot_pkg::local_state_t seen;
        waited        = 0;
        pulses        = 0;
        ready_at      = 0;
        seen          = '0;
        errors_before = error_count;
        check_state(idx, "held record", update_state, last_result);
        @(posedge clk);
        #1;
        fi_sender_id    = case_fi_sender[idx];
        local_sender_id = case_local_sender[idx];
        fi_state        = case_fi[idx];
        local_state     = case_local[idx];
        enable          = 1'b1;
        while (waited < 12 && (pulses == 0 || waited < ready_at + 3)) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited == 2) begin
                enable = 1'b0;                      // held high over two edges
            end
            if (update_ready) begin
                pulses++;
                if (pulses == 1) begin
                    ready_at = waited;
                    seen     = update_state;
                end
            end
        end
        if (pulses == 0) begin
            error_count++;
            $display("case %0d: no ready pulse arrived within 12 cycles", idx);
        end else begin
            check_ready(idx, ready_at, 1 + 3);      // edge detect, then three edges
            check_state(idx, "updated record", seen, case_expected[idx]);
            if (pulses > 1) begin
                error_count++;
                $display("case %0d: ready pulsed %0d times for one enable", idx, pulses);
            end
        end
        while (i_dut.i_sequencer.state != slot_pkg::seq_idle) begin
            @(posedge clk);
            #1;
        end
        last_result = case_expected[idx];
        $display("case %0d %s", idx, (error_count == errors_before) ? "passed" : "failed");
    endtask

    initial begin
        reset           = 1'b0;
        enable          = 1'b0;
        fi_sender_id    = '0;
        local_sender_id = '0;
        fi_state        = '0;
        local_state     = '0;
        last_result     = '0;                       // cleared by reset
        load_cases();
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b1;
        check_count++;
        if (update_ready !== 1'b0) begin
            error_count++;
            $display("error at %0t ns: update_ready is high after reset", $time);
        end
        for (int i = 0; i < num_cases; i++) begin
            run_case(i);
        end
        $display("%0d cases, %0d checks, %0d errors", num_cases, check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+logic
+incdir+test
logic/slot_pkg.sv
logic/update_sequencer.sv
logic/slot_update_rules.sv
logic/slot_update_top.sv
test/tb_slot_update.sv
